// File: hw/rvj1_isa_pkg.sv
package rvj1_isa_pkg;

  ////////////////////////////////////////////////////////////
  // Architectural widths
  ////////////////////////////////////////////////////////////
  localparam int unsigned XLEN  = 32;  // Data and address width
  localparam int unsigned RALEN = 5;   // Register index width

  ////////////////////////////////////////////////////////////
  // Major opcodes of the supported subset
  ////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OPCODE_LOAD  = 7'b000_0011,
    OPCODE_OPIMM = 7'b001_0011,
    OPCODE_AUIPC = 7'b001_0111,
    OPCODE_STORE = 7'b010_0011,
    OPCODE_OP    = 7'b011_0011,
    OPCODE_LUI   = 7'b011_0111
  } opcode_e;

  // funct3 of the integer group, shared by OP and OP-IMM
  typedef enum logic [2:0] {
    F3_ADDI      = 3'b000,  // Also ADD/SUB
    F3_SLLI      = 3'b001,
    F3_SLTI      = 3'b010,
    F3_SLTIU     = 3'b011,
    F3_XORI      = 3'b100,
    F3_SRLI_SRAI = 3'b101,
    F3_ORI       = 3'b110,
    F3_ANDI      = 3'b111
  } f3_imm_e;

  // funct7 picks the alternate form, bit 30 set
  typedef enum logic [6:0] {
    F7_SLLI_SRLI_ADDI = 7'b000_0000,
    F7_SRAI_SUB       = 7'b010_0000
  } f7_shift_imm_e;

  // Fetch side request, instruction word with its address
  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
  } ifu_req_t;

endpackage

// File: hw/rvj1_ctrl_pkg.sv
package rvj1_ctrl_pkg;

  // ALU function select
  typedef enum logic [3:0] {
    ALU_OP_ADD,
    ALU_OP_SUB,
    ALU_OP_SLT,
    ALU_OP_SLTU,
    ALU_OP_XOR,
    ALU_OP_OR,
    ALU_OP_AND,
    ALU_OP_SLL,
    ALU_OP_SRL,
    ALU_OP_SRA
  } alu_op_e;

  // LSU command, {write, funct3}
  typedef enum logic [3:0] {
    LSU_LOAD_8    = 4'b0000,
    LSU_LOAD_16   = 4'b0001,
    LSU_LOAD_32   = 4'b0010,
    LSU_LOAD_8_U  = 4'b0100,
    LSU_LOAD_16_U = 4'b0101,
    LSU_STORE_8   = 4'b1000,
    LSU_STORE_16  = 4'b1001,
    LSU_STORE_32  = 4'b1010,
    LSU_NO_CMD    = 4'b1111   // Idle
  } lsu_ctrl_e;

  ////////////////////////////////////////////////////////////
  // Decoded bundle, decode stage to execute stage
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [rvj1_isa_pkg::RALEN-1:0] rf_addr_a;
    logic [rvj1_isa_pkg::RALEN-1:0] rf_addr_b;
    alu_op_e                        alu_sel;
    logic                           rpa_or_pc;     // ALU A from PC
    logic                           rpb_or_imm;    // ALU B from immediate
    logic                           alu_write_rf;
    logic [rvj1_isa_pkg::RALEN-1:0] alu_regdest;
    logic [rvj1_isa_pkg::XLEN-1:0]  immediate;     // Sign extended
    logic                           lsu_ctrl_valid;
    lsu_ctrl_e                      lsu_ctrl;
    logic [rvj1_isa_pkg::RALEN-1:0] lsu_regdest;
    logic [rvj1_isa_pkg::XLEN-1:0]  pc;
  } dec_ctrl_t;

  // Register file write port as seen outside
  typedef struct packed {
    logic                           valid;
    logic [rvj1_isa_pkg::RALEN-1:0] addr;
    logic [rvj1_isa_pkg::XLEN-1:0]  data;
  } wb_t;

endpackage

// File: hw/rvj1_dec.sv
`timescale 1ns/10ps

module rvj1_dec (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  rvj1_isa_pkg::ifu_req_t  ifu_req_i,
  input  logic                    ifu_valid_i,
  output logic                    ifu_ready_o,
  input  logic                    stall_i,
  output logic                    instr_issued_o,
  output rvj1_ctrl_pkg::dec_ctrl_t ctrl_o
);

  // Empty slot, nothing written and no memory access
  localparam rvj1_ctrl_pkg::dec_ctrl_t BUBBLE = '{
    alu_sel:  rvj1_ctrl_pkg::ALU_OP_ADD,
    lsu_ctrl: rvj1_ctrl_pkg::LSU_NO_CMD,
    default:  '0
  };

  logic                             ifu_fire;
  rvj1_ctrl_pkg::dec_ctrl_t         ctrl_d;    // Next bundle

  logic [6:0]                       opcode;
  logic [rvj1_isa_pkg::RALEN-1:0]   rd;
  logic [rvj1_isa_pkg::RALEN-1:0]   rs1;
  logic [rvj1_isa_pkg::RALEN-1:0]   rs2;
  logic [2:0]                       funct3;
  logic [6:0]                       funct7;
  rvj1_isa_pkg::f7_shift_imm_e      f7_eff;    // funct7 as the ALU sees it
  logic [rvj1_isa_pkg::XLEN-1:0]    imm_i;
  logic [rvj1_isa_pkg::XLEN-1:0]    imm_s;
  logic [rvj1_isa_pkg::XLEN-1:0]    imm_u;

  ////////////////////////////////////////////////////////////
  // Instruction fields and immediates
  ////////////////////////////////////////////////////////////
  assign opcode = ifu_req_i.instr[6:0];
  assign rd     = ifu_req_i.instr[11:7];
  assign funct3 = ifu_req_i.instr[14:12];
  assign rs1    = ifu_req_i.instr[19:15];
  assign rs2    = ifu_req_i.instr[24:20];
  assign funct7 = ifu_req_i.instr[31:25];

  assign imm_i = {{20{ifu_req_i.instr[31]}}, ifu_req_i.instr[31:20]};
  assign imm_s = {{20{ifu_req_i.instr[31]}}, ifu_req_i.instr[31:25], ifu_req_i.instr[11:7]};
  assign imm_u = {ifu_req_i.instr[31:12], 12'b0};

  // Shift ops only, funct3 001 and 101
  function automatic logic is_shift(input rvj1_isa_pkg::f3_imm_e f3);
    return (f3 == rvj1_isa_pkg::F3_SLLI) || (f3 == rvj1_isa_pkg::F3_SRLI_SRAI);
  endfunction

  function automatic rvj1_ctrl_pkg::alu_op_e f3_7_to_alu_op(
    input rvj1_isa_pkg::f3_imm_e       f3,
    input rvj1_isa_pkg::f7_shift_imm_e f7
  );
    rvj1_ctrl_pkg::alu_op_e op;
    op = rvj1_ctrl_pkg::ALU_OP_ADD;
    case (f3)
      rvj1_isa_pkg::F3_ADDI:  op = (f7 == rvj1_isa_pkg::F7_SRAI_SUB) ?
                                   rvj1_ctrl_pkg::ALU_OP_SUB : rvj1_ctrl_pkg::ALU_OP_ADD;
      rvj1_isa_pkg::F3_SLLI:  op = rvj1_ctrl_pkg::ALU_OP_SLL;
      rvj1_isa_pkg::F3_SLTI:  op = rvj1_ctrl_pkg::ALU_OP_SLT;
      rvj1_isa_pkg::F3_SLTIU: op = rvj1_ctrl_pkg::ALU_OP_SLTU;
      rvj1_isa_pkg::F3_XORI:  op = rvj1_ctrl_pkg::ALU_OP_XOR;
      rvj1_isa_pkg::F3_ORI:   op = rvj1_ctrl_pkg::ALU_OP_OR;
      rvj1_isa_pkg::F3_ANDI:  op = rvj1_ctrl_pkg::ALU_OP_AND;
      rvj1_isa_pkg::F3_SRLI_SRAI: op = (f7 == rvj1_isa_pkg::F7_SRAI_SUB) ?
                                   rvj1_ctrl_pkg::ALU_OP_SRA : rvj1_ctrl_pkg::ALU_OP_SRL;
      default: op = rvj1_ctrl_pkg::ALU_OP_ADD;
    endcase
    return op;
  endfunction

  function automatic rvj1_ctrl_pkg::lsu_ctrl_e f3_to_lsu_ctrl(
    input logic [2:0] f3,
    input logic       is_write
  );
    return rvj1_ctrl_pkg::lsu_ctrl_e'({is_write, f3});
  endfunction

  // OP-IMM non-shift: bits 31:25 belong to the immediate
  assign f7_eff = (opcode == rvj1_isa_pkg::OPCODE_OPIMM &&
                   !is_shift(rvj1_isa_pkg::f3_imm_e'(funct3))) ?
                  rvj1_isa_pkg::F7_SLLI_SRLI_ADDI : rvj1_isa_pkg::f7_shift_imm_e'(funct7);

  ////////////////////////////////////////////////////////////
  // Combinational decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    ctrl_d    = BUBBLE;        // Unsupported opcodes stay a bubble
    ctrl_d.pc = ifu_req_i.pc;
    case (opcode)
      rvj1_isa_pkg::OPCODE_OPIMM, rvj1_isa_pkg::OPCODE_OP: begin
        ctrl_d.rf_addr_a    = rs1;
        ctrl_d.rf_addr_b    = (opcode == rvj1_isa_pkg::OPCODE_OP) ? rs2 : '0;
        ctrl_d.alu_sel      = f3_7_to_alu_op(rvj1_isa_pkg::f3_imm_e'(funct3), f7_eff);
        ctrl_d.rpb_or_imm   = (opcode == rvj1_isa_pkg::OPCODE_OPIMM);
        ctrl_d.immediate    = imm_i;
        ctrl_d.alu_write_rf = 1'b1;
        ctrl_d.alu_regdest  = rd;
      end
      rvj1_isa_pkg::OPCODE_LUI, rvj1_isa_pkg::OPCODE_AUIPC: begin
        ctrl_d.rpa_or_pc    = (opcode == rvj1_isa_pkg::OPCODE_AUIPC); // LUI adds x0
        ctrl_d.rpb_or_imm   = 1'b1;
        ctrl_d.immediate    = imm_u;
        ctrl_d.alu_write_rf = 1'b1;
        ctrl_d.alu_regdest  = rd;
      end
      rvj1_isa_pkg::OPCODE_STORE: begin
        ctrl_d.rf_addr_a      = rs1;   // Base
        ctrl_d.rf_addr_b      = rs2;   // Store data
        ctrl_d.rpb_or_imm     = 1'b1;
        ctrl_d.immediate      = imm_s;
        ctrl_d.lsu_ctrl_valid = 1'b1;
        ctrl_d.lsu_ctrl       = f3_to_lsu_ctrl(funct3, 1'b1);
      end
      rvj1_isa_pkg::OPCODE_LOAD: begin
        ctrl_d.rf_addr_b      = rs1;   // Base on port b
        ctrl_d.rpb_or_imm     = 1'b1;
        ctrl_d.immediate      = imm_i;
        ctrl_d.lsu_ctrl_valid = 1'b1;
        ctrl_d.lsu_ctrl       = f3_to_lsu_ctrl(funct3, 1'b0);
        ctrl_d.lsu_regdest    = rd;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Decode register and issue pulse
  ////////////////////////////////////////////////////////////
  assign ifu_ready_o = ~stall_i;
  assign ifu_fire    = ifu_valid_i & ifu_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      instr_issued_o <= 1'b0;
      ctrl_o         <= BUBBLE;
    end else begin
      instr_issued_o <= ifu_fire;
      if (ifu_fire) ctrl_o <= ctrl_d;
      else if (!stall_i) ctrl_o <= BUBBLE;  // Held under stall
    end
  end

  // Issue only after a request offered while not stalled
  a_issue_follows_fire: assert property (@(posedge clk_i) disable iff (!rstn_i)
    instr_issued_o |-> $past(ifu_valid_i && !stall_i));

endmodule

// File: hw/rvj1_regfile.sv
`timescale 1ns/10ps

module rvj1_regfile (
  input  logic                          clk_i,
  input  logic                          rstn_i,
  input  logic                          issue_i,
  input  rvj1_ctrl_pkg::dec_ctrl_t      ctrl_i,
  input  logic [rvj1_isa_pkg::XLEN-1:0] alu_res_i,
  input  logic [rvj1_isa_pkg::XLEN-1:0] lsu_res_i,
  output logic [rvj1_isa_pkg::XLEN-1:0] rs_a_o,
  output logic [rvj1_isa_pkg::XLEN-1:0] rs_b_o,
  output rvj1_ctrl_pkg::wb_t            wb_o
);

  logic [rvj1_isa_pkg::XLEN-1:0] regs [1:31];  // x0 not stored
  logic [3:0]                    lsu_cmd;
  logic                          alu_wr;
  logic                          lsu_wr;

  assign lsu_cmd = ctrl_i.lsu_ctrl;
  assign alu_wr  = issue_i & ctrl_i.alu_write_rf;
  assign lsu_wr  = issue_i & ctrl_i.lsu_ctrl_valid & ~lsu_cmd[3];  // Loads only

  // Write source select, x0 targets dropped
  always_comb begin
    wb_o.addr  = alu_wr ? ctrl_i.alu_regdest : ctrl_i.lsu_regdest;
    wb_o.data  = alu_wr ? alu_res_i : lsu_res_i;
    wb_o.valid = (alu_wr | lsu_wr) && (wb_o.addr != '0);
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (wb_o.valid) begin
      regs[wb_o.addr] <= wb_o.data;
    end
  end

  assign rs_a_o = (ctrl_i.rf_addr_a == '0) ? '0 : regs[ctrl_i.rf_addr_a];
  assign rs_b_o = (ctrl_i.rf_addr_b == '0) ? '0 : regs[ctrl_i.rf_addr_b];

  // Decoder never marks one slot as both ALU write and load
  a_single_wb_source: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(alu_wr && lsu_wr));

endmodule

// File: hw/rvj1_alu.sv
`timescale 1ns/10ps

module rvj1_alu (
  input  rvj1_ctrl_pkg::dec_ctrl_t      ctrl_i,
  input  logic [rvj1_isa_pkg::XLEN-1:0] rs_a_i,
  input  logic [rvj1_isa_pkg::XLEN-1:0] rs_b_i,
  output logic [rvj1_isa_pkg::XLEN-1:0] res_o
);

  logic [rvj1_isa_pkg::XLEN-1:0] op_a;
  logic [rvj1_isa_pkg::XLEN-1:0] op_b;
  logic [4:0]                    shamt;

  ////////////////////////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////////////////////////
  assign op_a  = ctrl_i.rpa_or_pc  ? ctrl_i.pc        : rs_a_i;  // AUIPC
  assign op_b  = ctrl_i.rpb_or_imm ? ctrl_i.immediate : rs_b_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl_i.alu_sel)
      rvj1_ctrl_pkg::ALU_OP_ADD:  res_o = op_a + op_b;
      rvj1_ctrl_pkg::ALU_OP_SUB:  res_o = op_a - op_b;
      rvj1_ctrl_pkg::ALU_OP_SLT:
        res_o = {31'b0, $signed(op_a) < $signed(op_b)};
      rvj1_ctrl_pkg::ALU_OP_SLTU: res_o = {31'b0, op_a < op_b};
      rvj1_ctrl_pkg::ALU_OP_XOR:  res_o = op_a ^ op_b;
      rvj1_ctrl_pkg::ALU_OP_OR:   res_o = op_a | op_b;
      rvj1_ctrl_pkg::ALU_OP_AND:  res_o = op_a & op_b;
      rvj1_ctrl_pkg::ALU_OP_SLL:  res_o = op_a << shamt;
      rvj1_ctrl_pkg::ALU_OP_SRL:  res_o = op_a >> shamt;
      rvj1_ctrl_pkg::ALU_OP_SRA:
        res_o = rvj1_isa_pkg::XLEN'($signed(op_a) >>> shamt);  // Sign fill
      default:                    res_o = op_a + op_b;
    endcase
  end

endmodule

// File: hw/rvj1_lsu.sv
`timescale 1ns/10ps

module rvj1_lsu #(
  parameter int unsigned DMEM_WORDS = 256
) (
  input  logic                          clk_i,
  input  logic                          rstn_i,
  input  logic                          issue_i,
  input  rvj1_ctrl_pkg::dec_ctrl_t      ctrl_i,
  input  logic [rvj1_isa_pkg::XLEN-1:0] rs_a_i,
  input  logic [rvj1_isa_pkg::XLEN-1:0] rs_b_i,
  output logic [rvj1_isa_pkg::XLEN-1:0] load_data_o
);

  localparam int unsigned IDXW = $clog2(DMEM_WORDS);

  logic [rvj1_isa_pkg::XLEN-1:0] mem [DMEM_WORDS];
  logic [3:0]                    lsu_cmd;     // {write, funct3}
  logic                          is_write;
  logic [rvj1_isa_pkg::XLEN-1:0] addr;
  logic [IDXW-1:0]               idx;
  logic [3:0]                    be;          // Store byte enables
  logic [rvj1_isa_pkg::XLEN-1:0] wdata;
  logic [rvj1_isa_pkg::XLEN-1:0] rword;       // Read word shifted down

  assign lsu_cmd  = ctrl_i.lsu_ctrl;
  assign is_write = lsu_cmd[3];
  // Store base on port a, load base on port b
  assign addr = (is_write ? rs_a_i : rs_b_i) + ctrl_i.immediate;
  assign idx  = IDXW'(addr[rvj1_isa_pkg::XLEN-1:2] % DMEM_WORDS);

  ////////////////////////////////////////////////////////////
  // Store path
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (lsu_cmd[1:0])
      2'b00:   begin be = 4'b0001 << addr[1:0]; wdata = {4{rs_b_i[7:0]}};  end
      2'b01:   begin be = 4'b0011 << addr[1:0]; wdata = {2{rs_b_i[15:0]}}; end
      default: begin be = 4'b1111;              wdata = rs_b_i;            end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int w = 0; w < int'(DMEM_WORDS); w++) mem[w] <= '0;
    end else if (issue_i && ctrl_i.lsu_ctrl_valid && is_write) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) mem[idx][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Load path, asynchronous read
  ////////////////////////////////////////////////////////////
  assign rword = mem[idx] >> {addr[1:0], 3'b000};

  always_comb begin
    case (ctrl_i.lsu_ctrl)
      rvj1_ctrl_pkg::LSU_LOAD_8:    load_data_o = {{24{rword[7]}}, rword[7:0]};
      rvj1_ctrl_pkg::LSU_LOAD_16:   load_data_o = {{16{rword[15]}}, rword[15:0]};
      rvj1_ctrl_pkg::LSU_LOAD_8_U:  load_data_o = {24'b0, rword[7:0]};
      rvj1_ctrl_pkg::LSU_LOAD_16_U: load_data_o = {16'b0, rword[15:0]};
      default:                      load_data_o = rword;   // LW
    endcase
  end

  // Halves on even, words on 4-byte boundaries
  a_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (issue_i && ctrl_i.lsu_ctrl_valid) |->
      ((lsu_cmd[1:0] == 2'b01 && !addr[0]) || (lsu_cmd[1:0] == 2'b10 && addr[1:0] == 2'b00)
       || (lsu_cmd[1:0] == 2'b00)));

endmodule

// File: hw/rvj1_core.sv
`timescale 1ns/10ps

module rvj1_core #(
  parameter int unsigned DMEM_WORDS = 256
) (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  rvj1_isa_pkg::ifu_req_t ifu_req_i,
  input  logic                   ifu_valid_i,
  output logic                   ifu_ready_o,
  input  logic                   stall_i,
  output logic                   instr_issued_o,
  output rvj1_ctrl_pkg::wb_t     wb_o
);

  rvj1_ctrl_pkg::dec_ctrl_t      ctrl;      // Execute stage bundle
  logic [rvj1_isa_pkg::XLEN-1:0] rs_a;
  logic [rvj1_isa_pkg::XLEN-1:0] rs_b;
  logic [rvj1_isa_pkg::XLEN-1:0] alu_res;
  logic [rvj1_isa_pkg::XLEN-1:0] lsu_res;

  ////////////////////////////////////////////////////////////
  // Decode stage
  ////////////////////////////////////////////////////////////
  rvj1_dec u_dec (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .ifu_req_i      (ifu_req_i),
    .ifu_valid_i    (ifu_valid_i),
    .ifu_ready_o    (ifu_ready_o),
    .stall_i        (stall_i),
    .instr_issued_o (instr_issued_o),
    .ctrl_o         (ctrl)
  );

  ////////////////////////////////////////////////////////////
  // Execute stage
  ////////////////////////////////////////////////////////////
  rvj1_regfile u_regfile (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .issue_i   (instr_issued_o),   // Write enable qualifier
    .ctrl_i    (ctrl),
    .alu_res_i (alu_res),
    .lsu_res_i (lsu_res),
    .rs_a_o    (rs_a),
    .rs_b_o    (rs_b),
    .wb_o      (wb_o)
  );

  rvj1_alu u_alu (
    .ctrl_i (ctrl),
    .rs_a_i (rs_a),
    .rs_b_i (rs_b),
    .res_o  (alu_res)
  );

  rvj1_lsu #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_lsu (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .issue_i     (instr_issued_o),
    .ctrl_i      (ctrl),
    .rs_a_i      (rs_a),
    .rs_b_i      (rs_b),
    .load_data_o (lsu_res)
  );

endmodule

// File: sim/rvj1_model.svh
`ifndef RVJ1_MODEL_SVH
`define RVJ1_MODEL_SVH

// Architectural state of the reference
logic [31:0] model_regs [32];
logic [7:0]  model_mem  [DMEM_WORDS*4];  // Byte image, wraps like the data array

function automatic void model_clear();
  foreach (model_regs[i]) model_regs[i] = '0;
  foreach (model_mem[i]) model_mem[i] = '0;
endfunction

// RV32I integer group, alt picks SUB or SRA
function automatic logic [31:0] int_op(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
  logic [31:0] r;
  case (f3)
    3'd0:    r = alt ? a - b : a + b;
    3'd1:    r = a << b[4:0];
    3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    r = (a < b) ? 32'd1 : 32'd0;
    3'd4:    r = a ^ b;
    3'd5:    r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

// Executes one instruction, reports the register update if any
function automatic void exec_one(input logic [31:0] instr, input logic [31:0] pc,
                                 output logic wr, output logic [4:0] rd,
                                 output logic [31:0] val);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  int unsigned bi;   // Byte index in model memory
  int unsigned nb;   // Access size in bytes
  a     = model_regs[instr[19:15]];
  b     = model_regs[instr[24:20]];
  imm_i = {{20{instr[31]}}, instr[31:20]};
  imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  rd    = instr[11:7];
  wr    = 1'b1;
  val   = '0;
  nb    = 1 << instr[13:12];
  case (instr[6:0])
    7'h13: val = int_op(instr[14:12], instr[14:12] == 3'd5 && instr[30], a, imm_i);
    7'h33: val = int_op(instr[14:12], instr[30], a, b);
    7'h37: val = {instr[31:12], 12'h0};        // LUI
    7'h17: val = pc + {instr[31:12], 12'h0};   // AUIPC
    7'h03: begin
      bi = (a + imm_i) % (DMEM_WORDS * 4);
      for (int i = 0; i < int'(nb); i++)
        val[8*i +: 8] = model_mem[bi + i];
      case (instr[13:12])   // instr[14] marks the unsigned forms
        2'd0:    val = instr[14] ? {24'h0, val[7:0]} : {{24{val[7]}}, val[7:0]};
        2'd1:    val = instr[14] ? {16'h0, val[15:0]} : {{16{val[15]}}, val[15:0]};
        default: ;
      endcase
    end
    7'h23: begin
      bi = (a + imm_s) % (DMEM_WORDS * 4);
      for (int i = 0; i < int'(nb); i++)
        model_mem[bi + i] = b[8*i +: 8];   // Little endian lanes
      wr = 1'b0;
    end
    default: wr = 1'b0;
  endcase
  if (rd == 5'd0) wr = 1'b0;   // x0 stays zero
  if (wr) model_regs[rd] = val;
endfunction

`endif

// File: sim/rvj1_tb.sv
`timescale 1ns/10ps

module rvj1_tb;

  localparam int unsigned DMEM_WORDS = 256;
  localparam int unsigned N_INSTR    = 400;
  localparam int unsigned MAX_CYCLES = N_INSTR * 6 + 100;
  localparam logic [31:0] SEED       = 32'hdd5c_c4c6;

  `include "rvj1_model.svh"

  logic                   clk_i;
  logic                   rstn_i;
  rvj1_isa_pkg::ifu_req_t ifu_req_i;
  logic                   ifu_valid_i;
  logic                   ifu_ready_o;
  logic                   stall_i;
  logic                   instr_issued_o;
  rvj1_ctrl_pkg::wb_t     wb_o;

  rvj1_ctrl_pkg::wb_t exp_q [$];   // Expected write-backs, oldest first
  int unsigned n_sent;
  int unsigned n_issued;
  int unsigned cycles;
  int unsigned val_errs;
  int unsigned other_errs;
  logic        fire_q;             // Acceptance seen at the previous edge

  rvj1_core #(.DMEM_WORDS(DMEM_WORDS)) u_rvj1_core (
    .clk_i, .rstn_i, .ifu_req_i, .ifu_valid_i, .ifu_ready_o,
    .stall_i, .instr_issued_o, .wb_o
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Random instruction source
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] gen_instr(input int unsigned idx);
    logic [31:0] instr;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    int          off;
    if (idx == 0) return {20'h00001, 5'd1, 7'h37};            // LUI x1
    if (idx == 1) return {12'h200, 5'd1, 3'd0, 5'd1, 7'h13};  // x1 = 0x1200
    rd  = 5'($urandom_range(0, 31));
    if (rd == 5'd1) rd = 5'd0;   // Base never overwritten
    rs1 = 5'($urandom_range(0, 31));
    rs2 = 5'($urandom_range(0, 31));
    f3  = 3'($urandom_range(0, 7));
    alt = 1'($urandom_range(0, 1));
    imm = 12'($urandom);
    case ($urandom_range(0, 6))
      0, 1: begin   // OP-IMM, shifts carry shamt only
        if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt && f3 == 3'd5, 5'd0, imm[4:0]};
        instr = {imm, rs1, f3, rd, 7'h13};
      end
      2, 3: instr = {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'd0, rs2, rs1, f3, rd, 7'h33};
      4:    instr = {20'($urandom), rd, alt ? 7'h17 : 7'h37};
      5: begin   // Loads off x1, LB LH LW LBU LHU
        f3 = 3'($urandom_range(0, 4));
        if (f3 == 3'd3) f3 = 3'd5;
        off = int'($urandom_range(0, 63)) - 32;
        imm = 12'(off & ~((1 << f3[1:0]) - 1));   // Natural alignment
        instr = {imm, 5'd1, f3, rd, 7'h03};
      end
      default: begin   // Stores off x1
        f3  = 3'($urandom_range(0, 2));
        off = int'($urandom_range(0, 63)) - 32;
        imm = 12'(off & ~((1 << f3[1:0]) - 1));
        instr = {imm[11:5], rs2, 5'd1, f3, imm[4:0], 7'h23};
      end
    endcase
    return instr;
  endfunction

  task automatic print_counts();
    $display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Driver and write-back checker
  ////////////////////////////////////////////////////////////
  always @(posedge clk_i) begin
    rvj1_ctrl_pkg::wb_t exp;
    logic               wr;
    logic [4:0]         rd;
    logic [31:0]        val;
    if (rstn_i) begin
      cycles++;
      if (ifu_ready_o !== !stall_i) begin   // Ready is the inverse of stall
        $display("CHECK FAILED at %0t: ifu_ready_o %b with stall_i %b",
                 $time, ifu_ready_o, stall_i);
        val_errs++;
      end
      if (instr_issued_o !== fire_q) begin   // One pulse per acceptance
        $display("CHECK FAILED at %0t: instr_issued_o %b, expected %b",
                 $time, instr_issued_o, fire_q);
        val_errs++;
      end
      if (instr_issued_o) n_issued++;
      if (wb_o.valid) begin
        if (exp_q.size() == 0) begin
          $display("Write-back to x%0d at %0t with nothing outstanding", wb_o.addr, $time);
          other_errs++;
        end else begin
          exp = exp_q.pop_front();
          if (wb_o.addr !== exp.addr || wb_o.data !== exp.data) begin
            $display("CHECK FAILED at %0t: write-back x%0d=%h, expected x%0d=%h",
                     $time, wb_o.addr, wb_o.data, exp.addr, exp.data);
            val_errs++;
          end
        end
      end
      fire_q = ifu_valid_i && !stall_i;
      if (fire_q) begin   // Model runs in acceptance order
        exec_one(ifu_req_i.instr, ifu_req_i.pc, wr, rd, val);
        if (wr) begin
          exp.valid = 1'b1;
          exp.addr  = rd;
          exp.data  = val;
          exp_q.push_back(exp);
        end
        n_sent++;
        if (n_sent < N_INSTR) begin
          ifu_req_i.instr <= gen_instr(n_sent);
          ifu_req_i.pc    <= ifu_req_i.pc + 32'd4;
        end
      end
      ifu_valid_i <= (n_sent < N_INSTR) && ($urandom_range(0, 3) != 0);
      stall_i     <= ($urandom_range(0, 3) == 0);
    end
  end

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    model_clear();
    clk_i       = 1'b0;
    rstn_i      = 1'b0;
    ifu_valid_i = 1'b0;
    stall_i     = 1'b0;
    fire_q      = 1'b0;
    ifu_req_i.instr = gen_instr(0);
    ifu_req_i.pc    = 32'h0;
    repeat (4) @(posedge clk_i);
    rstn_i <= 1'b1;
    while (n_sent < N_INSTR || exp_q.size() != 0) @(posedge clk_i);
    repeat (3) @(posedge clk_i);   // Catch stray write-backs
    if (n_issued != n_sent) begin
      $display("Issued %0d instructions but accepted %0d", n_issued, n_sent);
      other_errs++;
    end
    print_counts();
    if (val_errs == 0 && other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    wait (cycles >= MAX_CYCLES);
    $display("Timeout after %0d cycles, %0d accepted, %0d write-backs outstanding",
             cycles, n_sent, exp_q.size());
    print_counts();
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+sim
hw/rvj1_isa_pkg.sv
hw/rvj1_ctrl_pkg.sv
hw/rvj1_dec.sv
hw/rvj1_regfile.sv
hw/rvj1_alu.sv
hw/rvj1_lsu.sv
hw/rvj1_core.sv
sim/rvj1_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := rvj1_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
